//--- common/alu_pkg.sv
// shared types for the 8-bit handshaked ALU; struct widths follow DATA_W, not module parameters
`default_nettype none

package alu_pkg;

    // operand width, power of two
    localparam int DATA_W = 8;

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_NEG = 2'd2,
        OP_CMP = 2'd3
    } opcode_e;

    typedef enum logic [1:0] {
        DS_IDLE   = 2'd0,
        DS_ISSUED = 2'd1,
        DS_WAIT   = 2'd2
    } dec_state_e;

    typedef struct packed {
        opcode_e             opcode;
        logic [DATA_W-1:0]   a;
        logic [DATA_W-1:0]   b;
    } alu_req_t;

    // adder operands plus what the result mux needs
    typedef struct packed {
        logic [DATA_W-1:0]   x;
        logic [DATA_W-1:0]   y;
        logic                carry_in;
        logic                pass_a;
        logic [DATA_W-1:0]   a;
    } micro_op_t;

    typedef struct packed {
        logic c;
        logic z;
        logic n;
        logic v;
    } flags_t;

    typedef struct packed {
        logic [DATA_W-1:0]   result;
        flags_t              flags;
    } alu_resp_t;

endpackage

`default_nettype wire

//--- prefix_adder/kogge_stone_adder.sv
// WIDTH must be a power of two and at least 2; purely combinational, no pipelining
`timescale 1ns/100ps
`default_nettype none

module kogge_stone_adder #(
    parameter int WIDTH = 8
) (
    input  wire logic [WIDTH-1:0] x,
    input  wire logic [WIDTH-1:0] y,
    input  wire logic             carry_in,
    output logic      [WIDTH-1:0] sum,
    output logic                  carry_out,
    output logic                  carry_msb
);

    localparam int LEVELS = $clog2(WIDTH);

    logic [WIDTH-1:0] p;
    logic [WIDTH-1:0] g;

    // group generate / propagate per prefix level
    logic [WIDTH-1:0] gg [0:LEVELS];
    logic [WIDTH-1:0] pp [0:LEVELS];

    assign p = x ^ y;
    assign g = x & y;

    // carry-in folded into bit 0 so the tree needs no extra stage
    assign gg[0] = {g[WIDTH-1:1], g[0] | (p[0] & carry_in)};
    assign pp[0] = p;

    genvar lvl;
    genvar i;
    generate
        for (lvl = 0; lvl < LEVELS; lvl++) begin : g_level
            localparam int DIST = 1 << lvl;
            for (i = 0; i < WIDTH; i++) begin : g_bit
                if (i >= DIST) begin : g_combine
                    assign gg[lvl+1][i] = gg[lvl][i] | (pp[lvl][i] & gg[lvl][i-DIST]);
                    assign pp[lvl+1][i] = pp[lvl][i] & pp[lvl][i-DIST];
                end else begin : g_pass
                    assign gg[lvl+1][i] = gg[lvl][i];
                    assign pp[lvl+1][i] = pp[lvl][i];
                end
            end
        end
    endgenerate

    // gg[LEVELS][i] is the carry out of bit i
    assign sum       = p ^ {gg[LEVELS][WIDTH-2:0], carry_in};
    assign carry_out = gg[LEVELS][WIDTH-1];
    assign carry_msb = gg[LEVELS][WIDTH-2];

endmodule

`default_nettype wire

//--- source/op_decode.sv
// one request per four-phase handshake; request must stay stable while req is high
`timescale 1ns/100ps
`default_nettype none

module op_decode (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                req,
    input  wire alu_pkg::alu_req_t   request,
    input  wire logic                release_pulse,
    output alu_pkg::micro_op_t       uop,
    output logic                     uop_valid
);

    alu_pkg::dec_state_e state;
    alu_pkg::micro_op_t  uop_d;
    logic                accept;

    assign accept = (state == alu_pkg::DS_IDLE) && req;

    // opcode to adder operands
    always_comb begin
        uop_d          = '0;
        uop_d.a        = request.a;
        uop_d.x        = request.a;
        uop_d.y        = ~request.b;
        uop_d.carry_in = 1'b1;
        case (request.opcode)
            alu_pkg::OP_ADD: begin
                uop_d.y        = request.b;
                uop_d.carry_in = 1'b0;
            end
            alu_pkg::OP_NEG: begin
                uop_d.x = '0;
            end
            alu_pkg::OP_CMP: begin
                uop_d.pass_a = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= alu_pkg::DS_IDLE;
            uop_valid <= 1'b0;
        end else begin
            uop_valid <= accept;
            case (state)
                alu_pkg::DS_IDLE:   if (req) state <= alu_pkg::DS_ISSUED;
                alu_pkg::DS_ISSUED: state <= alu_pkg::DS_WAIT;
                alu_pkg::DS_WAIT:   if (release_pulse) state <= alu_pkg::DS_IDLE;
                default:            state <= alu_pkg::DS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            uop <= uop_d;
        end
    end

    // a release outside DS_WAIT would be lost
    a_release_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        release_pulse |-> (state == alu_pkg::DS_WAIT));

endmodule

`default_nettype wire

//--- source/alu_execute.sv
// WIDTH must equal alu_pkg::DATA_W; result and flags registered, one cycle latency
`timescale 1ns/100ps
`default_nettype none

module alu_execute #(
    parameter int WIDTH = 8
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire alu_pkg::micro_op_t  uop,
    input  wire logic                uop_valid,
    output alu_pkg::alu_resp_t       resp,
    output logic                     resp_valid
);

    logic [WIDTH-1:0]   sum;
    logic               carry_out;
    logic               carry_msb;
    alu_pkg::alu_resp_t resp_d;

    generate
        if (WIDTH != alu_pkg::DATA_W) begin : g_width_check
            $error("alu_execute WIDTH must match alu_pkg::DATA_W");
        end
    endgenerate

    kogge_stone_adder #(
        .WIDTH(WIDTH)
    ) u_adder (
        .x         (uop.x),
        .y         (uop.y),
        .carry_in  (uop.carry_in),
        .sum       (sum),
        .carry_out (carry_out),
        .carry_msb (carry_msb)
    );

    // flags always come from the adder, compare only swaps the result
    always_comb begin
        resp_d.result  = uop.pass_a ? uop.a : sum;
        resp_d.flags.c = carry_out;
        resp_d.flags.z = (sum == '0);
        resp_d.flags.n = sum[WIDTH-1];
        resp_d.flags.v = carry_msb ^ carry_out;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= uop_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (uop_valid) begin
            resp <= resp_d;
        end
    end

    // decoder issues one single-cycle pulse per request
    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        uop_valid |=> !uop_valid);

endmodule

`default_nettype wire

//--- source/result_stage.sv
// holds the response for the requester; ack drops only after req is seen low
`timescale 1ns/100ps
`default_nettype none

module result_stage (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                req,
    input  wire alu_pkg::alu_resp_t  resp_in,
    input  wire logic                resp_valid,
    output alu_pkg::alu_resp_t       resp,
    output logic                     ack,
    output logic                     release_pulse
);

    logic ack_done;

    // requester has let go of its side
    assign ack_done = ack && !req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp          <= '0;
            ack           <= 1'b0;
            release_pulse <= 1'b0;
        end else begin
            release_pulse <= 1'b0;
            if (resp_valid) begin
                resp <= resp_in;
                ack  <= 1'b1;
            end else if (ack_done) begin
                ack           <= 1'b0;
                release_pulse <= 1'b1;
            end
        end
    end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req));

    a_resp_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (ack && $past(ack)) |-> $stable(resp));

    // second transfer must not overlap the first
    a_no_valid_during_ack: assert property (@(posedge clk) disable iff (!rst_n)
        ack |-> !resp_valid);

endmodule

`default_nettype wire

//--- source/alu_top.sv
// single outstanding request; four-phase req/ack, response valid while ack is high
`timescale 1ns/100ps
`default_nettype none

module alu_top (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                req,
    input  wire alu_pkg::alu_req_t   request,
    output logic                     ack,
    output alu_pkg::alu_resp_t       response
);

    alu_pkg::micro_op_t uop;
    logic               uop_valid;
    alu_pkg::alu_resp_t exec_resp;
    logic               exec_valid;
    logic               release_pulse;

    op_decode u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .request       (request),
        .release_pulse (release_pulse),
        .uop           (uop),
        .uop_valid     (uop_valid)
    );

    alu_execute #(
        .WIDTH(alu_pkg::DATA_W)
    ) u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .uop        (uop),
        .uop_valid  (uop_valid),
        .resp       (exec_resp),
        .resp_valid (exec_valid)
    );

    result_stage u_result (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .resp_in       (exec_resp),
        .resp_valid    (exec_valid),
        .resp          (response),
        .ack           (ack),
        .release_pulse (release_pulse)
    );

endmodule

`default_nettype wire

//--- testbench/tb_alu_top.sv
// run from the project root so testbench/alu_cases.txt opens; one idle cycle between transfers
`timescale 1ns/100ps
`default_nettype none

module tb_alu_top;

    logic               clk;
    logic               rst_n;
    logic               req;
    alu_pkg::alu_req_t  request;
    logic               ack;
    alu_pkg::alu_resp_t response;

    alu_pkg::alu_req_t  case_req[$];
    alu_pkg::alu_resp_t case_exp[$];

    int errors;
    int tests;
    int cycle_count;
    int limit_cycles;

    alu_top uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .request  (request),
        .ack      (ack),
        .response (response)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_result(input string name, input logic [alu_pkg::DATA_W-1:0] got,
                                input logic [alu_pkg::DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flags(input string name, input alu_pkg::flags_t got,
                               input alu_pkg::flags_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h (c z n v)", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // reference for add and subtract, straight from the arithmetic definitions
    function automatic alu_pkg::alu_resp_t expect_arith(input alu_pkg::opcode_e op,
            input logic [alu_pkg::DATA_W-1:0] a, input logic [alu_pkg::DATA_W-1:0] b);
        logic [alu_pkg::DATA_W:0] wide;
        logic                     sa;
        logic                     sb;
        logic                     sr;
        alu_pkg::alu_resp_t       r;
        if (op == alu_pkg::OP_ADD) begin
            wide = {1'b0, a} + {1'b0, b};
        end else begin
            wide = {1'b0, a} - {1'b0, b};
        end
        r.result  = wide[alu_pkg::DATA_W-1:0];
        sa        = a[alu_pkg::DATA_W-1];
        sb        = b[alu_pkg::DATA_W-1];
        sr        = r.result[alu_pkg::DATA_W-1];
        r.flags.c = (op == alu_pkg::OP_ADD) ? wide[alu_pkg::DATA_W] : (a >= b);
        r.flags.z = (r.result == '0);
        r.flags.n = sr;
        if (op == alu_pkg::OP_ADD) begin
            r.flags.v = (sa == sb) && (sr != sa);
        end else begin
            r.flags.v = (sa != sb) && (sr != sa);
        end
        return r;
    endfunction

    // one four-phase transfer, req held for hold extra cycles after ack
    task automatic run_transfer(input alu_pkg::alu_req_t rq, input alu_pkg::alu_resp_t exp,
                                input int hold);
        int                  lat;
        int                  errs_before;
        alu_pkg::opcode_e    op;
        errs_before = errors;
        op = rq.opcode;
        @(negedge clk);
        request = rq;
        req = 1'b1;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!ack);
        // first edge samples req, ack is seen after two more
        if (lat != 3) begin
            $display("ack came %0d cycles after req was sampled instead of 2", lat - 1);
            errors++;
        end
        check_result("response.result", response.result, exp.result);
        check_flags("response.flags", response.flags, exp.flags);
        repeat (hold) begin
            @(negedge clk);
            check_bit("ack", ack, 1'b1);
            check_result("response.result", response.result, exp.result);
            check_flags("response.flags", response.flags, exp.flags);
        end
        req = 1'b0;
        do begin
            @(negedge clk);
        end while (ack);
        tests++;
        $display("test %0d %s a=%h b=%h hold=%0d: %s", tests, op.name(), rq.a, rq.b, hold,
                 (errors == errs_before) ? "ok" : "FAILED");
    endtask

    // ends the run if the handshake stalls
    initial begin
        cycle_count = 0;
        while (limit_cycles == 0 || cycle_count < limit_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, ack never arrived", cycle_count);
        $display("Errors found");
        $finish;
    end

    initial begin
        int                 fd;
        int                 k;
        int                 seed;
        logic [8*120-1:0]   line;
        logic [31:0]        f_op;
        logic [31:0]        f_a;
        logic [31:0]        f_b;
        logic [31:0]        f_res;
        logic [31:0]        f_flg;
        alu_pkg::alu_req_t  rq;
        alu_pkg::alu_resp_t ex;

        rst_n        = 1'b0;
        req          = 1'b0;
        request      = '0;
        errors       = 0;
        tests        = 0;
        limit_cycles = 0;
        seed         = 32'h75b5_2693;

        fd = $fopen("testbench/alu_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file testbench/alu_cases.txt");
            errors++;
        end else begin
            // comment and blank lines fail the scan and are skipped
            while ($fgets(line, fd) != 0) begin
                if ($sscanf(line, "%h %h %h %h %h", f_op, f_a, f_b, f_res, f_flg) == 5) begin
                    rq.opcode = alu_pkg::opcode_e'(f_op[1:0]);
                    rq.a      = f_a[alu_pkg::DATA_W-1:0];
                    rq.b      = f_b[alu_pkg::DATA_W-1:0];
                    ex.result = f_res[alu_pkg::DATA_W-1:0];
                    ex.flags  = alu_pkg::flags_t'(f_flg[3:0]);
                    case_req.push_back(rq);
                    case_exp.push_back(ex);
                end
            end
            $fclose(fd);
        end
        limit_cycles = 12 * (case_req.size() + 40) + 100;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        @(negedge clk);
        check_bit("ack", ack, 1'b0);
        check_result("response.result", response.result, '0);
        check_flags("response.flags", response.flags, '0);
        tests++;
        $display("test %0d reset: %s", tests, (errors == 0) ? "ok" : "FAILED");

        for (k = 0; k < case_req.size(); k++) begin
            run_transfer(case_req[k], case_exp[k], (k % 3) * 2);
        end

        for (k = 0; k < 40; k++) begin
            rq.opcode = ($random(seed) & 1) ? alu_pkg::OP_SUB : alu_pkg::OP_ADD;
            rq.a      = 8'($random(seed));
            rq.b      = 8'($random(seed));
            run_transfer(rq, expect_arith(rq.opcode, rq.a, rq.b), k % 2);
        end

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/alu_cases.txt
# opcode (0 add, 1 sub, 2 neg, 3 cmp)  a  b  expected result  expected flags
# flags nibble is {c, z, n, v}, all columns in hex
0 03 05 08 0
0 7F 01 80 3
0 FF 01 00 C
0 80 80 00 D
0 C8 64 2C 8
0 50 50 A0 3
0 00 00 00 4
1 05 03 02 8
1 03 05 FE 2
1 80 01 7F 9
1 7F FF 80 3
1 42 42 00 C
1 00 01 FF 2
2 5A 00 00 C
2 5A 80 80 3
2 00 01 FF 2
2 00 FF 01 0
2 00 7F 81 2
3 10 10 10 C
3 10 20 10 2
3 20 10 20 8
3 80 01 80 9
3 00 00 00 C

//--- vlog.f
common/alu_pkg.sv
prefix_adder/kogge_stone_adder.sv
source/op_decode.sv
source/alu_execute.sv
source/result_stage.sv
source/alu_top.sv
testbench/tb_alu_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_alu_top -f vlog.f -o tb_alu_top
./obj_dir/tb_alu_top | tee sim.log

if grep -qx "No errors" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
